// ==== project.f ====
verilog/extractor_pkg.sv
verilog/extractor_ifs.sv
verilog/buffer_ram.sv
verilog/buffer_control.sv
verilog/engine_writer.sv
verilog/mac_transmitter.sv
verilog/api_stats.sv
verilog/nts_extractor.sv
tests/extractor_checker.sv
tests/tb_nts_extractor.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the NTS extractor testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary -f project.f --top-module tb_nts_extractor -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Simulation failed" sim.log; then
  echo "FAIL"
  exit 1
fi
echo "PASS"

// ==== tests/extractor_checker.sv ====
// NTS extractor checker
// Watches engine FIFO pops, MAC output and register reads, keeps
// the expected packets and counter totals, and compares every cycle
`timescale 1ns/1ps

module extractor_checker #(
  parameter int API_ADDR_WIDTH = 12,
  parameter int API_ADDR_BASE  = 'h400
) (
  input  logic                      i_clk,
  input  logic                      i_areset,
  input  logic                      i_engine_fifo_rd_en,
  input  logic                      i_engine_packet_read,
  input  extractor_pkg::word_t      i_engine_fifo_rd_data,
  input  extractor_pkg::lwdv_t      i_engine_bytes_last_word,
  input  logic                      i_mac_tx_start,
  input  logic                      i_mac_tx_ack,
  input  extractor_pkg::word_t      i_mac_tx_data,
  input  extractor_pkg::mask_t      i_mac_tx_data_valid,
  input  logic                      i_api_cs,
  input  logic                      i_api_we,
  input  logic [API_ADDR_WIDTH-1:0] i_api_address,
  input  extractor_pkg::api_data_t  i_api_read_data,
  output int                        o_errors,
  output int                        o_checks,
  output int                        o_packets
);

  // ASCII identity as given for the core
  localparam logic [63:0] NAME    = "NTS-EXTR";
  localparam logic [31:0] VERSION = "0.01";

  extractor_pkg::word_t exp_words [$];
  int                   exp_len [$];
  extractor_pkg::lwdv_t exp_lwdv [$];
  int                   build_len = 0;
  extractor_pkg::word_t word0;
  extractor_pkg::lwdv_t cur_lwdv;
  int                   cur_len = 0;
  int                   idx = 0;
  bit                   holding = 0;
  bit                   in_pkt = 0;
  logic [63:0]          tot_bytes = 0;

  initial begin
    o_errors  = 0;
    o_checks  = 0;
    o_packets = 0;
  end

  // Contiguous low mask for a last-word byte count
  function automatic extractor_pkg::mask_t low_mask(input extractor_pkg::lwdv_t n);
    return extractor_pkg::mask_t'((9'd1 << n) - 9'd1);
  endfunction

  // Byte order reversed, invalid lanes zero
  function automatic extractor_pkg::word_t lane_view(input extractor_pkg::word_t w,
                                                     input extractor_pkg::mask_t m);
    extractor_pkg::word_t r;
    r = {<<8{w}};
    for (int i = 0; i < 8; i++) begin
      if (!m[i]) r[8*i +: 8] = 8'h00;
    end
    return r;
  endfunction

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    o_checks++;
    if (got !== exp) begin
      o_errors++;
      $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // --------------------
  // MAC stream
  // --------------------
  task automatic mac_step();
    extractor_pkg::mask_t m;
    if (i_mac_tx_start) begin
      if (in_pkt || holding) begin
        o_errors++;
        $display("ERROR t=%0t start came before the previous packet ended", $time);
      end
      if (exp_len.size() == 0) begin
        o_errors++;
        $display("ERROR t=%0t start came with no packet popped from the engine", $time);
      end else begin
        cur_len  = exp_len.pop_front();
        cur_lwdv = exp_lwdv.pop_front();
        word0    = exp_words.pop_front();
        compare("o_mac_tx_data", i_mac_tx_data, lane_view(word0, 8'hff));
        compare("o_mac_tx_data_valid", 64'(i_mac_tx_data_valid), 64'hff);
        idx     = 1;
        in_pkt  = 1;
        holding = !i_mac_tx_ack;
      end
    end else if (holding) begin
      // Word 0 stays put until ack
      compare("o_mac_tx_data", i_mac_tx_data, lane_view(word0, 8'hff));
      compare("o_mac_tx_data_valid", 64'(i_mac_tx_data_valid), 64'hff);
      holding = !i_mac_tx_ack;
    end else if (in_pkt && idx < cur_len) begin
      m = (idx == cur_len - 1) ? low_mask(cur_lwdv) : 8'hff;
      compare("o_mac_tx_data", i_mac_tx_data, lane_view(exp_words.pop_front(), m));
      compare("o_mac_tx_data_valid", 64'(i_mac_tx_data_valid), 64'(m));
      idx++;
    end else if (in_pkt) begin
      // The one silent cycle
      compare("o_mac_tx_data", i_mac_tx_data, 64'h0);
      compare("o_mac_tx_data_valid", 64'(i_mac_tx_data_valid), 64'h0);
      in_pkt = 0;
      o_packets++;
      tot_bytes = tot_bytes + 64'((cur_len - 1) * 8 + int'(cur_lwdv));
      $display("packet %0d: %0d words, %0d bytes in last word, done",
               o_packets, cur_len, cur_lwdv);
    end else begin
      compare("o_mac_tx_data_valid", 64'(i_mac_tx_data_valid), 64'h0);
    end
  endtask

  task automatic api_step();
    int          off;
    logic [63:0] exp;
    off = int'(i_api_address) - API_ADDR_BASE;
    case (off)
      0:       exp = 64'(NAME[63:32]);
      1:       exp = 64'(NAME[31:0]);
      2:       exp = 64'(VERSION);
      10:      exp = 64'(tot_bytes[63:32]);
      11:      exp = 64'(tot_bytes[31:0]);
      12:      exp = 64'h0;
      13:      exp = 64'(o_packets);
      default: exp = 64'h0;
    endcase
    compare("o_api_read_data", 64'(i_api_read_data), exp);
  endtask

  // Sample mid-cycle, all inputs settled
  always @(negedge i_clk) begin
    if (i_areset) begin
      compare("o_mac_tx_start", 64'(i_mac_tx_start), 64'h0);
      compare("o_mac_tx_data_valid", 64'(i_mac_tx_data_valid), 64'h0);
      compare("o_engine_fifo_rd_en", 64'(i_engine_fifo_rd_en), 64'h0);
      compare("o_engine_packet_read", 64'(i_engine_packet_read), 64'h0);
    end else begin
      if (i_engine_fifo_rd_en) begin
        if (build_len == 0) exp_lwdv.push_back(i_engine_bytes_last_word);
        exp_words.push_back(i_engine_fifo_rd_data);
        build_len++;
      end
      if (i_engine_packet_read) begin
        exp_len.push_back(build_len);
        build_len = 0;
      end
      mac_step();
      if (i_api_cs && !i_api_we) api_step();
    end
  end

endmodule

// ==== tests/tb_nts_extractor.sv ====
// NTS extractor testbench
// Random packets from an LCG go through an engine FIFO model, a MAC
// ack model answers each start, registers are read before and after
`timescale 1ns/1ps

module tb_nts_extractor;

  localparam int NUM_PKTS = 40;
  localparam int LIMIT    = NUM_PKTS * (66 + 6 + 10) + 200;
  localparam int BASE     = 'h400;

  logic                     clk = 1'b0;
  logic                     areset;
  logic                     api_cs;
  logic                     api_we;
  logic [11:0]              api_address;
  extractor_pkg::api_data_t api_read_data;
  logic                     packet_available;
  logic                     packet_read;
  logic                     fifo_empty;
  logic                     fifo_rd_en;
  extractor_pkg::word_t     fifo_data;
  extractor_pkg::lwdv_t     last_bytes;
  logic                     tx_start;
  logic                     tx_ack;
  extractor_pkg::mask_t     tx_valid;
  extractor_pkg::word_t     tx_data;
  int                       errors;
  int                       checks;
  int                       packets;
  int unsigned              lcg_state = 73;
  int                       cycles = 0;
  // Ack delay per transmitted packet in start order
  int                       ack_delay [NUM_PKTS];
  int                       acks = 0;

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 1103515245 + 12345;
    // Upper half of the state has the longest period
    return lcg_state >> 16;
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'(lcg_next() % (hi - lo + 1));
  endfunction

  always #5 clk = ~clk;

  nts_extractor u_dut (
    .i_clk(clk), .i_areset(areset),
    .i_api_cs(api_cs), .i_api_we(api_we), .i_api_address(api_address),
    .o_api_read_data(api_read_data),
    .i_engine_packet_available(packet_available), .o_engine_packet_read(packet_read),
    .i_engine_fifo_empty(fifo_empty), .o_engine_fifo_rd_en(fifo_rd_en),
    .i_engine_fifo_rd_data(fifo_data), .i_engine_bytes_last_word(last_bytes),
    .o_mac_tx_start(tx_start), .i_mac_tx_ack(tx_ack),
    .o_mac_tx_data_valid(tx_valid), .o_mac_tx_data(tx_data)
  );

  extractor_checker u_chk (
    .i_clk(clk), .i_areset(areset),
    .i_engine_fifo_rd_en(fifo_rd_en), .i_engine_packet_read(packet_read),
    .i_engine_fifo_rd_data(fifo_data), .i_engine_bytes_last_word(last_bytes),
    .i_mac_tx_start(tx_start), .i_mac_tx_ack(tx_ack),
    .i_mac_tx_data(tx_data), .i_mac_tx_data_valid(tx_valid),
    .i_api_cs(api_cs), .i_api_we(api_we), .i_api_address(api_address),
    .i_api_read_data(api_read_data),
    .o_errors(errors), .o_checks(checks), .o_packets(packets)
  );

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("Run stopped after %0d cycles, the DUT stopped making progress", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  // One ack pulse per start after that packet's delay
  always @(posedge clk) begin
    if (tx_start) begin
      repeat ((acks < NUM_PKTS) ? ack_delay[acks] : 0) @(posedge clk);
      acks++;
      tx_ack <= 1'b1;
      @(posedge clk);
      tx_ack <= 1'b0;
    end
  end

  task automatic api_read(input int ofs);
    @(posedge clk);
    api_cs      <= 1'b1;
    api_address <= 12'(BASE + ofs);
    @(posedge clk);
    api_cs      <= 1'b0;
  endtask

  // --------------------
  // Engine FIFO model
  // --------------------
  task automatic send_packet(input bit short_pkt);
    extractor_pkg::word_t words [64];
    int                   len;
    int                   idx;
    len = short_pkt ? rand_range(2, 4) : rand_range(2, 64);
    for (int i = 0; i < len; i++) begin
      for (int k = 0; k < 4; k++) begin
        words[i] = {words[i][47:0], 16'(lcg_next())};
      end
    end
    repeat (rand_range(0, 3)) @(posedge clk);
    fifo_data        <= words[0];
    fifo_empty       <= 1'b0;
    packet_available <= 1'b1;
    last_bytes       <= 4'(rand_range(1, 8));
    idx = 0;
    while (idx < len) begin
      @(posedge clk);
      if (fifo_rd_en) begin
        idx++;
        if (idx < len) begin
          fifo_data <= words[idx];
        end else begin
          fifo_empty       <= 1'b1;
          packet_available <= 1'b0;
        end
      end
    end
    do @(posedge clk); while (!packet_read);
  endtask

  initial begin
    areset           = 1'b1;
    api_cs           = 1'b0;
    api_we           = 1'b0;
    api_address      = '0;
    packet_available = 1'b0;
    fifo_empty       = 1'b1;
    fifo_data        = '0;
    last_bytes       = 4'd1;
    tx_ack           = 1'b0;
    // Second half backs the MAC up so the ring fills
    for (int p = 0; p < NUM_PKTS; p++) begin
      ack_delay[p] = (p >= NUM_PKTS / 2) ? 6 : rand_range(0, 6);
    end
    repeat (2) @(posedge clk);
    areset <= 1'b0;
    api_read(0);
    api_read(1);
    api_read(2);
    $display("test reset_state: done");
    for (int p = 0; p < NUM_PKTS; p++) begin
      send_packet(p >= NUM_PKTS / 2);
    end
    while (packets < NUM_PKTS) @(posedge clk);
    $display("test traffic: %0d packets through the ring", packets);
    api_read(10);
    api_read(11);
    api_read(12);
    api_read(13);
    api_read(5);
    api_read(100);
    $display("test counters: done");
    repeat (2) @(posedge clk);
    $display("checks %0d, errors %0d, packets %0d", checks, errors, packets);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== verilog/api_stats.sv ====
// Statistics and register read port
// Counts transmitted bytes and packets from the MAC side, keeps a
// low half snapshot per counter and decodes reads from the base
`timescale 1ns/1ps

module api_stats #(
  parameter int API_ADDR_WIDTH = 12,
  parameter int API_ADDR_BASE  = 'h400
) (
  input  logic                      i_clk,
  input  logic                      i_areset,
  input  logic                      i_api_cs,
  input  logic                      i_api_we,
  input  logic [API_ADDR_WIDTH-1:0] i_api_address,
  output extractor_pkg::api_data_t  o_api_read_data,
  input  logic                      i_mac_tx_start,
  input  logic                      i_mac_tx_ack,
  input  extractor_pkg::mask_t      i_mac_tx_data_valid
);

  extractor_pkg::counter_t   bytes_cnt;
  extractor_pkg::counter_t   packets_cnt;
  extractor_pkg::api_data_t  bytes_lo;
  extractor_pkg::api_data_t  packets_lo;
  logic [API_ADDR_WIDTH-1:0] offset;
  logic                      rd;
  logic                      hold;
  logic                      count_en;

  assign offset = i_api_address - API_ADDR_WIDTH'(API_ADDR_BASE);
  assign rd     = i_api_cs && !i_api_we;

  // Word 0 is held until ack, count it once
  assign count_en = (i_mac_tx_data_valid != '0) && !hold;

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      bytes_cnt   <= '0;
      packets_cnt <= '0;
      bytes_lo    <= '0;
      packets_lo  <= '0;
      hold        <= 1'b0;
    end else begin
      hold <= (i_mac_tx_start || hold) && !i_mac_tx_ack;
      if (count_en) begin
        bytes_cnt <= bytes_cnt + 64'($countones(i_mac_tx_data_valid));
      end
      if (i_mac_tx_start) begin
        packets_cnt <= packets_cnt + 1'b1;
      end
      // High half read freezes the low half
      if (rd && offset == extractor_pkg::OFS_BYTES) begin
        bytes_lo <= bytes_cnt[31:0];
      end
      if (rd && offset == extractor_pkg::OFS_PACKETS) begin
        packets_lo <= packets_cnt[31:0];
      end
    end
  end

  // --------------------
  // Read decoder
  // --------------------

  always_comb begin
    o_api_read_data = '0;
    if (rd) begin
      case (offset)
        extractor_pkg::OFS_NAME0:       o_api_read_data = extractor_pkg::CORE_NAME[63:32];
        extractor_pkg::OFS_NAME1:       o_api_read_data = extractor_pkg::CORE_NAME[31:0];
        extractor_pkg::OFS_VERSION:     o_api_read_data = extractor_pkg::CORE_VERSION;
        extractor_pkg::OFS_BYTES:       o_api_read_data = bytes_cnt[63:32];
        extractor_pkg::OFS_BYTES + 1:   o_api_read_data = bytes_lo;
        extractor_pkg::OFS_PACKETS:     o_api_read_data = packets_cnt[63:32];
        extractor_pkg::OFS_PACKETS + 1: o_api_read_data = packets_lo;
        default:                        o_api_read_data = '0;
      endcase
    end
  end

endmodule

// ==== verilog/buffer_control.sv ====
// Buffer ring control
// Keeps state, last word address and last word byte count per buffer,
// plus the engine and MAC ring pointers. Presents the engine buffer
// status to the writer and the MAC buffer status to the transmitter
`timescale 1ns/1ps

module buffer_control #(
  parameter int BUF_SEL_WIDTH   = 2,
  parameter int WORD_ADDR_WIDTH = 6
) (
  input logic i_clk,
  input logic i_areset,
  fill_if.ctrl  fill,
  drain_if.ctrl drain
);

  localparam int NUM_BUFS = 1 << BUF_SEL_WIDTH;

  extractor_pkg::buf_state_e  buf_state [NUM_BUFS];
  logic [WORD_ADDR_WIDTH-1:0] buf_last  [NUM_BUFS];
  extractor_pkg::lwdv_t       buf_lwdv  [NUM_BUFS];

  logic [BUF_SEL_WIDTH-1:0] engine_sel;
  logic [BUF_SEL_WIDTH-1:0] mac_sel;
  extractor_pkg::mask_t     lwdv_mask;

  // Byte count to contiguous low mask, 8 gives all lanes
  function automatic extractor_pkg::mask_t expand_lwdv(input extractor_pkg::lwdv_t lwdv);
    extractor_pkg::mask_t m;
    for (int i = 0; i < 8; i++) begin
      m[i] = (i < int'(lwdv));
    end
    return m;
  endfunction

  // --------------------
  // Status towards the datapath
  // --------------------

  assign fill.buf_sel = engine_sel;
  assign fill.free    = (buf_state[engine_sel] == extractor_pkg::UNUSED);

  assign drain.buf_sel   = mac_sel;
  assign drain.loaded    = (buf_state[mac_sel] == extractor_pkg::LOADED);
  assign drain.last_addr = buf_last[mac_sel];
  assign drain.lwdv_mask = lwdv_mask;

  // --------------------
  // State table and ring pointers
  // --------------------

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      for (int i = 0; i < NUM_BUFS; i++) begin
        buf_state[i] <= extractor_pkg::UNUSED;
      end
      engine_sel <= '0;
      mac_sel    <= '0;
      lwdv_mask  <= '0;
    end else begin
      // Engine side owns UNUSED and WRITING entries
      if (fill.begin_pkt) begin
        buf_state[engine_sel] <= extractor_pkg::WRITING;
      end
      if (fill.end_pkt) begin
        buf_state[engine_sel] <= extractor_pkg::LOADED;
        engine_sel            <= engine_sel + 1'b1;
      end
      // MAC side owns LOADED and READING entries
      if (drain.take) begin
        buf_state[mac_sel] <= extractor_pkg::READING;
      end
      if (drain.release_buf) begin
        buf_state[mac_sel] <= extractor_pkg::UNUSED;
        mac_sel            <= mac_sel + 1'b1;
      end
      // Follows the MAC buffer, settles a cycle after LOADED
      lwdv_mask <= expand_lwdv(buf_lwdv[mac_sel]);
    end
  end

  // Packet length and last word count, stored on packet end
  always_ff @(posedge i_clk) begin
    if (fill.end_pkt) begin
      buf_last[engine_sel] <= fill.last_addr;
      buf_lwdv[engine_sel] <= fill.lwdv;
    end
  end

endmodule

// ==== verilog/buffer_ram.sv ====
// Packet buffer memory
// Simple dual-port RAM, one write port, one read port with a
// registered output. Buffer select forms the upper address bits
`timescale 1ns/1ps

module buffer_ram #(
  parameter int BUF_SEL_WIDTH   = 2,
  parameter int WORD_ADDR_WIDTH = 6
) (
  input  logic                                     i_clk,
  input  logic                                     i_wr_en,
  input  logic [BUF_SEL_WIDTH+WORD_ADDR_WIDTH-1:0] i_wr_addr,
  input  extractor_pkg::word_t                     i_wr_data,
  input  logic [BUF_SEL_WIDTH+WORD_ADDR_WIDTH-1:0] i_rd_addr,
  output extractor_pkg::word_t                     o_rd_data
);

  localparam int DEPTH = 1 << (BUF_SEL_WIDTH + WORD_ADDR_WIDTH);

  extractor_pkg::word_t mem [DEPTH];

  always_ff @(posedge i_clk) begin
    if (i_wr_en) begin
      mem[i_wr_addr] <= i_wr_data;
    end
    // Read data one cycle after the address
    o_rd_data <= mem[i_rd_addr];
  end

endmodule

// ==== verilog/engine_writer.sv ====
// Engine FIFO to buffer writer
// Pops a finished packet from the show-ahead engine FIFO into the
// buffer picked by the ring control. Writes go through one register
// stage so the RAM sees each word a cycle after its pop
`timescale 1ns/1ps

module engine_writer #(
  parameter int BUF_SEL_WIDTH   = 2,
  parameter int WORD_ADDR_WIDTH = 6
) (
  input  logic                                     i_clk,
  input  logic                                     i_areset,
  fill_if.writer                                   fill,
  input  logic                                     i_engine_packet_available,
  input  logic                                     i_engine_fifo_empty,
  input  extractor_pkg::word_t                     i_engine_fifo_rd_data,
  input  extractor_pkg::lwdv_t                     i_engine_bytes_last_word,
  output logic                                     o_engine_fifo_rd_en,
  output logic                                     o_engine_packet_read,
  output logic                                     o_wr_en,
  output logic [BUF_SEL_WIDTH+WORD_ADDR_WIDTH-1:0] o_wr_addr,
  output extractor_pkg::word_t                     o_wr_data
);

  typedef enum logic {W_IDLE, W_WRITING} wr_state_e;

  wr_state_e                  state;
  logic [WORD_ADDR_WIDTH-1:0] word_cnt;
  extractor_pkg::lwdv_t       lwdv_q;
  logic                       pkt_start;
  logic                       pop;

  // Free buffer, packet ready and a word on show
  assign pkt_start = (state == W_IDLE) && fill.free && i_engine_packet_available &&
                     !i_engine_fifo_empty;
  assign pop = pkt_start || ((state == W_WRITING) && !i_engine_fifo_empty);

  assign o_engine_fifo_rd_en = pop;
  assign fill.begin_pkt      = pkt_start;
  // First empty cycle closes the packet
  assign fill.end_pkt        = (state == W_WRITING) && i_engine_fifo_empty;
  assign fill.lwdv           = lwdv_q;
  assign fill.last_addr      = word_cnt - 1'b1;

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state                <= W_IDLE;
      word_cnt             <= '0;
      lwdv_q               <= '0;
      o_engine_packet_read <= 1'b0;
      o_wr_en              <= 1'b0;
    end else begin
      o_engine_packet_read <= fill.end_pkt;
      o_wr_en              <= pop;
      if (pkt_start) begin
        state  <= W_WRITING;
        lwdv_q <= i_engine_bytes_last_word;
      end
      if (pop) begin
        word_cnt <= word_cnt + 1'b1;
      end else if (fill.end_pkt) begin
        state    <= W_IDLE;
        word_cnt <= '0;
      end
    end
  end

  // Write pipeline payload
  always_ff @(posedge i_clk) begin
    if (pop) begin
      o_wr_addr <= {fill.buf_sel, word_cnt};
      o_wr_data <= i_engine_fifo_rd_data;
    end
  end

endmodule

// ==== verilog/extractor_ifs.sv ====
// Extractor internal interfaces
// fill_if  : buffer control towards the engine side writer
// drain_if : buffer control towards the MAC transmitter
`timescale 1ns/1ps

interface fill_if #(
  parameter int BUF_SEL_WIDTH   = 2,
  parameter int WORD_ADDR_WIDTH = 6
);
  logic [BUF_SEL_WIDTH-1:0]   buf_sel;
  // Selected buffer is UNUSED
  logic                       free;
  logic                       begin_pkt;
  logic                       end_pkt;
  extractor_pkg::lwdv_t       lwdv;
  logic [WORD_ADDR_WIDTH-1:0] last_addr;

  modport ctrl (output buf_sel, free, input begin_pkt, end_pkt, lwdv, last_addr);
  modport writer (input buf_sel, free, output begin_pkt, end_pkt, lwdv, last_addr);
endinterface

interface drain_if #(
  parameter int BUF_SEL_WIDTH   = 2,
  parameter int WORD_ADDR_WIDTH = 6
);
  logic                       loaded;
  logic [BUF_SEL_WIDTH-1:0]   buf_sel;
  logic [WORD_ADDR_WIDTH-1:0] last_addr;
  extractor_pkg::mask_t       lwdv_mask;
  // LOADED to READING
  logic                       take;
  // READING to UNUSED, ring pointer moves on
  logic                       release_buf;

  modport ctrl (output loaded, buf_sel, last_addr, lwdv_mask, input take, release_buf);
  modport tx (input loaded, buf_sel, last_addr, lwdv_mask, output take, release_buf);
endinterface

// ==== verilog/extractor_pkg.sv ====
// NTS extractor shared definitions
// Data path types, buffer and transmitter state encodings,
// core identity and the register map offsets
package extractor_pkg;

  // --------------------
  // Data path types
  // --------------------

  // One packet word as delivered by the engine
  typedef logic [63:0] word_t;
  // Byte lane valid mask towards the MAC, bit i for lane i
  typedef logic [7:0]  mask_t;
  // Bytes used in a packet's last word, 1 to 8
  typedef logic [3:0]  lwdv_t;
  typedef logic [63:0] counter_t;
  typedef logic [31:0] api_data_t;

  // --------------------
  // State encodings
  // --------------------

  // Buffer ring entry, walked in this order
  typedef enum logic [1:0] {
    UNUSED,
    WRITING,
    LOADED,
    READING
  } buf_state_e;

  typedef enum logic [2:0] {
    IDLE,
    PREFETCH,
    AWAIT_ACK,
    WRITE,
    SILENT
  } tx_state_e;

  // --------------------
  // Identity and register map
  // --------------------

  // ASCII "NTS-EXTR" and "0.01"
  parameter logic [63:0] CORE_NAME    = 64'h4e_54_53_2d_45_58_54_52;
  parameter logic [31:0] CORE_VERSION = 32'h30_2e_30_31;

  // Offsets from the register base
  parameter int OFS_NAME0   = 0;
  parameter int OFS_NAME1   = 1;
  parameter int OFS_VERSION = 2;
  // High half here, low half snapshot at +1
  parameter int OFS_BYTES   = 10;
  parameter int OFS_PACKETS = 12;

endpackage

// ==== verilog/mac_transmitter.sv ====
// MAC transmitter
// Streams a loaded buffer to the MAC. Word 0 goes out with start and
// is held until ack, the rest follows without gaps, then one all-zero
// cycle ends the packet. Bytes are reversed and masked per lane
`timescale 1ns/1ps

module mac_transmitter #(
  parameter int BUF_SEL_WIDTH   = 2,
  parameter int WORD_ADDR_WIDTH = 6
) (
  input  logic                                     i_clk,
  input  logic                                     i_areset,
  drain_if.tx                                      drain,
  output logic [BUF_SEL_WIDTH+WORD_ADDR_WIDTH-1:0] o_rd_addr,
  input  extractor_pkg::word_t                     i_rd_data,
  input  logic                                     i_mac_tx_ack,
  output logic                                     o_mac_tx_start,
  output extractor_pkg::word_t                     o_mac_tx_data,
  output extractor_pkg::mask_t                     o_mac_tx_data_valid
);

  extractor_pkg::tx_state_e   state;
  // Word index currently on i_rd_data
  logic [WORD_ADDR_WIDTH-1:0] cnt;
  logic [WORD_ADDR_WIDTH-1:0] rd_word;
  logic                       last_word;
  extractor_pkg::mask_t       word_mask;
  logic                       release_q;

  // Lane i carries stored byte 7-i where valid
  function automatic extractor_pkg::word_t swap_bytes(input extractor_pkg::word_t d,
                                                      input extractor_pkg::mask_t m);
    extractor_pkg::word_t r;
    for (int i = 0; i < 8; i++) begin
      r[8*i +: 8] = m[i] ? d[8*(7-i) +: 8] : 8'h00;
    end
    return r;
  endfunction

  assign last_word = (cnt == drain.last_addr);
  assign word_mask = last_word ? drain.lwdv_mask : '1;

  // --------------------
  // Read address, one word ahead
  // --------------------

  always_comb begin
    case (state)
      extractor_pkg::IDLE:      rd_word = '0;
      extractor_pkg::PREFETCH:  rd_word = WORD_ADDR_WIDTH'(1);
      // Keep word 1 on the read port until ack
      extractor_pkg::AWAIT_ACK: rd_word = i_mac_tx_ack ? cnt + 1'b1 : cnt;
      extractor_pkg::WRITE:     rd_word = cnt + 1'b1;
      default:                  rd_word = cnt;
    endcase
  end

  assign o_rd_addr         = {drain.buf_sel, rd_word};
  assign drain.take        = (state == extractor_pkg::IDLE) && drain.loaded;
  // Pulses with the zero cycle on the MAC side
  assign drain.release_buf = release_q;

  // --------------------
  // Transmit FSM
  // --------------------

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state               <= extractor_pkg::IDLE;
      cnt                 <= '0;
      release_q           <= 1'b0;
      o_mac_tx_start      <= 1'b0;
      o_mac_tx_data       <= '0;
      o_mac_tx_data_valid <= '0;
    end else begin
      cnt                 <= rd_word;
      release_q           <= 1'b0;
      o_mac_tx_start      <= 1'b0;
      o_mac_tx_data       <= '0;
      o_mac_tx_data_valid <= '0;
      case (state)
        extractor_pkg::IDLE: begin
          if (drain.loaded) begin
            state <= extractor_pkg::PREFETCH;
          end
        end
        extractor_pkg::PREFETCH: begin
          // Word 0 is on the read port now
          o_mac_tx_start      <= 1'b1;
          o_mac_tx_data       <= swap_bytes(i_rd_data, '1);
          o_mac_tx_data_valid <= '1;
          state               <= extractor_pkg::AWAIT_ACK;
        end
        extractor_pkg::AWAIT_ACK: begin
          if (i_mac_tx_ack) begin
            o_mac_tx_data       <= swap_bytes(i_rd_data, word_mask);
            o_mac_tx_data_valid <= word_mask;
            state <= last_word ? extractor_pkg::SILENT : extractor_pkg::WRITE;
          end else begin
            o_mac_tx_data       <= o_mac_tx_data;
            o_mac_tx_data_valid <= o_mac_tx_data_valid;
          end
        end
        extractor_pkg::WRITE: begin
          o_mac_tx_data       <= swap_bytes(i_rd_data, word_mask);
          o_mac_tx_data_valid <= word_mask;
          if (last_word) begin
            state <= extractor_pkg::SILENT;
          end
        end
        default: begin
          // Outputs drop to zero next cycle
          release_q <= 1'b1;
          state     <= extractor_pkg::IDLE;
        end
      endcase
    end
  end

endmodule

// ==== verilog/nts_extractor.sv ====
// NTS packet extractor, top level
// Engine packets are stored in a ring of buffers in one RAM and sent
// to the MAC as byte reversed 64-bit words. Register port gives the
// core identity and byte and packet counters
`timescale 1ns/1ps

module nts_extractor #(
  parameter int BUF_SEL_WIDTH   = 2,
  parameter int WORD_ADDR_WIDTH = 6,
  parameter int API_ADDR_WIDTH  = 12,
  parameter int API_ADDR_BASE   = 'h400
) (
  input  logic                      i_clk,
  input  logic                      i_areset,
  // Register bus
  input  logic                      i_api_cs,
  input  logic                      i_api_we,
  input  logic [API_ADDR_WIDTH-1:0] i_api_address,
  output extractor_pkg::api_data_t  o_api_read_data,
  // Engine FIFO, show-ahead
  input  logic                      i_engine_packet_available,
  output logic                      o_engine_packet_read,
  input  logic                      i_engine_fifo_empty,
  output logic                      o_engine_fifo_rd_en,
  input  extractor_pkg::word_t      i_engine_fifo_rd_data,
  input  extractor_pkg::lwdv_t      i_engine_bytes_last_word,
  // MAC transmit
  output logic                      o_mac_tx_start,
  input  logic                      i_mac_tx_ack,
  output extractor_pkg::mask_t      o_mac_tx_data_valid,
  output extractor_pkg::word_t      o_mac_tx_data
);

  localparam int RAM_ADDR_WIDTH = BUF_SEL_WIDTH + WORD_ADDR_WIDTH;

  logic                      wr_en;
  logic [RAM_ADDR_WIDTH-1:0] wr_addr;
  extractor_pkg::word_t      wr_data;
  logic [RAM_ADDR_WIDTH-1:0] rd_addr;
  extractor_pkg::word_t      rd_data;

  fill_if  #(.BUF_SEL_WIDTH(BUF_SEL_WIDTH), .WORD_ADDR_WIDTH(WORD_ADDR_WIDTH)) u_fill ();
  drain_if #(.BUF_SEL_WIDTH(BUF_SEL_WIDTH), .WORD_ADDR_WIDTH(WORD_ADDR_WIDTH)) u_drain ();

  buffer_control #(.BUF_SEL_WIDTH(BUF_SEL_WIDTH), .WORD_ADDR_WIDTH(WORD_ADDR_WIDTH)) u_ctrl (
    .i_clk    (i_clk),
    .i_areset (i_areset),
    .fill     (u_fill.ctrl),
    .drain    (u_drain.ctrl)
  );

  engine_writer #(.BUF_SEL_WIDTH(BUF_SEL_WIDTH), .WORD_ADDR_WIDTH(WORD_ADDR_WIDTH)) u_writer (
    .i_clk                     (i_clk),
    .i_areset                  (i_areset),
    .fill                      (u_fill.writer),
    .i_engine_packet_available (i_engine_packet_available),
    .i_engine_fifo_empty       (i_engine_fifo_empty),
    .i_engine_fifo_rd_data     (i_engine_fifo_rd_data),
    .i_engine_bytes_last_word  (i_engine_bytes_last_word),
    .o_engine_fifo_rd_en       (o_engine_fifo_rd_en),
    .o_engine_packet_read      (o_engine_packet_read),
    .o_wr_en                   (wr_en),
    .o_wr_addr                 (wr_addr),
    .o_wr_data                 (wr_data)
  );

  buffer_ram #(.BUF_SEL_WIDTH(BUF_SEL_WIDTH), .WORD_ADDR_WIDTH(WORD_ADDR_WIDTH)) u_ram (
    .i_clk     (i_clk),
    .i_wr_en   (wr_en),
    .i_wr_addr (wr_addr),
    .i_wr_data (wr_data),
    .i_rd_addr (rd_addr),
    .o_rd_data (rd_data)
  );

  mac_transmitter #(.BUF_SEL_WIDTH(BUF_SEL_WIDTH), .WORD_ADDR_WIDTH(WORD_ADDR_WIDTH)) u_tx (
    .i_clk               (i_clk),
    .i_areset            (i_areset),
    .drain               (u_drain.tx),
    .o_rd_addr           (rd_addr),
    .i_rd_data           (rd_data),
    .i_mac_tx_ack        (i_mac_tx_ack),
    .o_mac_tx_start      (o_mac_tx_start),
    .o_mac_tx_data       (o_mac_tx_data),
    .o_mac_tx_data_valid (o_mac_tx_data_valid)
  );

  api_stats #(.API_ADDR_WIDTH(API_ADDR_WIDTH), .API_ADDR_BASE(API_ADDR_BASE)) u_stats (
    .i_clk               (i_clk),
    .i_areset            (i_areset),
    .i_api_cs            (i_api_cs),
    .i_api_we            (i_api_we),
    .i_api_address       (i_api_address),
    .o_api_read_data     (o_api_read_data),
    .i_mac_tx_start      (o_mac_tx_start),
    .i_mac_tx_ack        (i_mac_tx_ack),
    .i_mac_tx_data_valid (o_mac_tx_data_valid)
  );

endmodule
